//--- hdl/digest_compare.sv
// ==========================================================================
// Word-by-word digest comparator with consistency checks on its own FSM and
// counter. Reports a done level, a multi-bit good value and an alert
// ==========================================================================

`timescale 1ns/1ps

module digest_compare
  import rom_check_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        start_i,
  output logic        done_o,
  output mubi4_t      good_o,
  // Word 0 in the low bits of both digests
  input  logic [63:0] digest_i,
  input  logic [63:0] exp_digest_i,
  output logic        alert_o
);

  localparam logic [DigestAw-1:0] LastIdx = DigestAw'(DigestWords - 1);

  cmp_state_e state_q, state_d;

  logic [DigestAw-1:0] idx_q;
  logic                idx_incr;
  logic                matches_q;
  logic [31:0]         digest_word, exp_word;
  mubi4_t              good_q;

  logic fsm_alert;
  logic start_alert;
  logic wait_idx_alert;
  logic done_idx_alert;

  // Waiting until started, Checking walks the words, Done is final
  always_comb begin
    state_d   = state_q;
    fsm_alert = 1'b0;
    case (state_q)
      CmpWaiting: begin
        if (start_i) state_d = CmpChecking;
      end
      CmpChecking: begin
        if (idx_q == LastIdx) state_d = CmpDone;
      end
      CmpDone: begin
        // Stays here
      end
      default: fsm_alert = 1'b1;
    endcase
  end

  // Counter moves only in Checking and parks on the last word
  assign idx_incr = (state_q == CmpChecking) && (idx_q != LastIdx);

  // Word under comparison
  assign digest_word = digest_i[idx_q*32 +: 32];
  assign exp_word    = exp_digest_i[idx_q*32 +: 32];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= CmpWaiting;
      idx_q     <= '0;
      matches_q <= 1'b1;
      good_q    <= MuBi4False;
    end else begin
      state_q <= state_d;
      if (idx_incr) begin
        idx_q <= idx_q + 1'b1;
      end
      // Sticky match, one mismatch fails the check
      if (state_q == CmpChecking) begin
        matches_q <= matches_q && (digest_word == exp_word);
      end
      // Good only once the walk has finished
      good_q <= ((state_q == CmpDone) && matches_q) ? MuBi4True : MuBi4False;
    end
  end

  assign done_o = (state_q == CmpDone);
  assign good_o = good_q;

  // Start is only legal while waiting
  assign start_alert    = start_i && (state_q != CmpWaiting);
  // Counter has to sit at zero before the walk
  assign wait_idx_alert = (state_q == CmpWaiting) && (idx_q != '0);
  // And at the last word once done
  assign done_idx_alert = (state_q == CmpDone) && (idx_q != LastIdx);

  assign alert_o = fsm_alert | start_alert | wait_idx_alert | done_idx_alert;

endmodule

//--- hdl/digest_engine.sv
// ==========================================================================
// Two-lane digest accumulator, takes one word per strobe and presents the
// running digest with lane A in the low word
// ==========================================================================

`timescale 1ns/1ps

module digest_engine
  import rom_check_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  // Restart from the IVs
  input  logic        clear_i,
  // One data word per strobe
  input  logic        word_valid_i,
  input  logic [31:0] word_i,
  // Running digest, word 0 is lane A
  output logic [63:0] digest_o
);

  logic [31:0] lane_a_q, lane_b_q;
  logic [31:0] lane_a_rot;
  logic [31:0] lane_a_d, lane_b_d;

  // Lane A rotated left
  assign lane_a_rot = (lane_a_q << DigestRot) | (lane_a_q >> (32 - DigestRot));

  // Mixing rule
  // Lane A takes the rotated value xored with the word
  assign lane_a_d = lane_a_rot ^ word_i;
  // Lane B accumulates the new lane A, wrapping at 2^32
  assign lane_b_d = lane_b_q + lane_a_d;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lane_a_q <= DigestIvA;
      lane_b_q <= DigestIvB;
    end else if (clear_i) begin
      // Clear wins over a word in the same cycle
      lane_a_q <= DigestIvA;
      lane_b_q <= DigestIvB;
    end else if (word_valid_i) begin
      lane_a_q <= lane_a_d;
      lane_b_q <= lane_b_d;
    end
  end

  // Lane A in the least significant word
  assign digest_o = {lane_b_q, lane_a_q};

endmodule

//--- hdl/image_mem.sv
// ==========================================================================
// Image storage, 64 words of 32 bits, one write port and a registered read
// ==========================================================================

`timescale 1ns/1ps

module image_mem
  import rom_check_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_ni,
  // Write port from the gated loader
  input  logic             we_i,
  input  logic [MemAw-1:0] waddr_i,
  input  logic [31:0]      wdata_i,
  // Read port, data one cycle after re_i
  input  logic             re_i,
  input  logic [MemAw-1:0] raddr_i,
  output logic [31:0]      rdata_o
);

  // Register array
  logic [31:0] mem_q [MemWords];

  // Write side
  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem_q[waddr_i] <= wdata_i;
    end
  end

  // Read register holds its value between reads
  // Cleared on reset so the output is defined before the first read
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_o <= '0;
    end else if (re_i) begin
      rdata_o <= mem_q[raddr_i];
    end
  end

endmodule

//--- hdl/rom_check_fsm.sv
// ==========================================================================
// Check sequencer, sweeps the data words into the digest engine, latches the
// expected digest, starts the comparator and gates host reads on the result
// ==========================================================================

`timescale 1ns/1ps

module rom_check_fsm
  import rom_check_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             check_start_i,
  // Loader write gating
  input  logic             load_we_i,
  output logic             mem_we_o,
  // Memory read port
  output logic             mem_re_o,
  output logic [MemAw-1:0] mem_raddr_o,
  input  logic [31:0]      mem_rdata_i,
  // Digest engine control
  output logic             eng_clear_o,
  output logic             eng_valid_o,
  // Comparator side
  output logic [63:0]      exp_digest_o,
  output logic             cmp_start_o,
  input  logic             cmp_done_i,
  input  mubi4_t           cmp_good_i,
  // Host read port
  input  logic             bus_req_i,
  input  logic [MemAw-1:0] bus_addr_i,
  output logic             bus_rvalid_o,
  output logic [31:0]      bus_rdata_o,
  // Start pulse outside idle
  output logic             start_alert_o
);

  seq_state_e state_q, state_d;

  logic [MemAw-1:0] addr_q;
  logic             seq_rd;
  logic             host_ok;
  logic             last_data, last_word;

  // Read pipeline tags, one cycle behind the memory address
  logic             sweep_rd_q;
  logic             exp_rd_q;
  logic             exp_sel_q;
  logic             bus_rd_q;
  logic             cmp_start_q;
  logic             release_q;

  logic [63:0]      exp_q;

  assign last_data = (addr_q == MemAw'(DataWords - 1));
  assign last_word = (addr_q == MemAw'(MemWords - 1));

  // Sequencer owns the read port while sweeping and latching
  assign seq_rd  = (state_q == SeqSweep) || (state_q == SeqExpect);
  // Host only gets the port when the sequencer is parked
  assign host_ok = (state_q == SeqIdle) || (state_q == SeqDone);

  always_comb begin
    state_d = state_q;
    case (state_q)
      SeqIdle: begin
        if (check_start_i) state_d = SeqSweep;
      end
      SeqSweep: begin
        if (last_data) state_d = SeqExpect;
      end
      SeqExpect: begin
        // Two reads, words 62 and 63
        if (last_word) state_d = SeqCompare;
      end
      SeqCompare: begin
        if (cmp_done_i) state_d = SeqDone;
      end
      SeqDone: begin
        // Terminal until reset
      end
      default: state_d = SeqIdle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= SeqIdle;
      addr_q      <= '0;
      sweep_rd_q  <= 1'b0;
      exp_rd_q    <= 1'b0;
      exp_sel_q   <= 1'b0;
      bus_rd_q    <= 1'b0;
      cmp_start_q <= 1'b0;
      release_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      // Address restarts at word 0 on a fresh check
      if (state_q == SeqIdle) begin
        addr_q <= '0;
      end else if (seq_rd) begin
        addr_q <= addr_q + 1'b1;
      end
      sweep_rd_q  <= (state_q == SeqSweep);
      exp_rd_q    <= (state_q == SeqExpect);
      exp_sel_q   <= last_word;
      bus_rd_q    <= bus_req_i;
      // Single start pulse on entry to SeqCompare
      cmp_start_q <= (state_q == SeqExpect) && last_word;
      // Host data released the cycle after entering SeqDone
      release_q   <= (state_q == SeqDone) && (cmp_good_i == MuBi4True);
    end
  end

  // Expected digest words, 62 goes to word 0 and 63 to word 1
  always_ff @(posedge clk_i) begin
    if (exp_rd_q) begin
      if (exp_sel_q) begin
        exp_q[63:32] <= mem_rdata_i;
      end else begin
        exp_q[31:0] <= mem_rdata_i;
      end
    end
  end

  assign exp_digest_o = exp_q;
  assign cmp_start_o  = cmp_start_q;

  // Loads only land while idle
  assign mem_we_o = load_we_i && (state_q == SeqIdle);

  // Read address mux between sweep and host
  assign mem_re_o    = seq_rd || (bus_req_i && host_ok);
  assign mem_raddr_o = seq_rd ? addr_q : bus_addr_i;

  // Engine restarts on the accepted start and takes data a cycle after each read
  assign eng_clear_o = (state_q == SeqIdle) && check_start_i;
  assign eng_valid_o = sweep_rd_q;

  // Every request answers, data is zero unless the image passed
  assign bus_rvalid_o = bus_rd_q;
  assign bus_rdata_o  = (bus_rd_q && release_q) ? mem_rdata_i : '0;

  assign start_alert_o = check_start_i && (state_q != SeqIdle);

endmodule

//--- hdl/rom_check_pkg.sv
// ==========================================================================
// Shared constants, state types and multi-bit boolean codes for the boot
// image checker. Modules pull these in with a wildcard import
// ==========================================================================

package rom_check_pkg;

  // Image geometry
  localparam int MemWords = 64;
  localparam int MemAw    = 6;

  // Top words of the image hold the expected digest
  localparam int DigestWords = 2;
  localparam int DataWords   = MemWords - DigestWords;

  // Width of the comparator word counter
  localparam int DigestAw = (DigestWords > 1) ? $clog2(DigestWords) : 1;

  // Lane initial values and lane A rotate amount
  localparam logic [31:0] DigestIvA = 32'h6A09E667;
  localparam logic [31:0] DigestIvB = 32'hBB67AE85;
  localparam int          DigestRot = 5;

  // 4-bit multi-bit boolean, any code other than true counts as not true
  typedef logic [3:0] mubi4_t;
  localparam mubi4_t MuBi4True  = 4'h6;
  localparam mubi4_t MuBi4False = 4'h9;

  // Check sequencer states
  typedef enum logic [2:0] {
    SeqIdle,
    SeqSweep,
    SeqExpect,
    SeqCompare,
    SeqDone
  } seq_state_e;

  // Comparator states, sparse so that single bit flips land in no valid state
  // Minimum Hamming distance between codes is 3
  typedef enum logic [4:0] {
    CmpWaiting  = 5'b00100,
    CmpChecking = 5'b10010,
    CmpDone     = 5'b11001
  } cmp_state_e;

endpackage

//--- hdl/rom_check_top.sv
// ==========================================================================
// Boot image checker top, ties the image memory, digest engine, sequencer
// and comparator together
// ==========================================================================

`timescale 1ns/1ps

module rom_check_top
  import rom_check_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_ni,
  // Loader
  input  logic             load_we_i,
  input  logic [MemAw-1:0] load_addr_i,
  input  logic [31:0]      load_data_i,
  // Check control and result
  input  logic             check_start_i,
  output logic             check_done_o,
  output mubi4_t           check_good_o,
  output logic             alert_o,
  // Host read port
  input  logic             bus_req_i,
  input  logic [MemAw-1:0] bus_addr_i,
  output logic             bus_rvalid_o,
  output logic [31:0]      bus_rdata_o
);

  // Memory
  logic             mem_we;
  logic             mem_re;
  logic [MemAw-1:0] mem_raddr;
  logic [31:0]      mem_rdata;

  // Engine
  logic             eng_clear;
  logic             eng_valid;
  logic [63:0]      digest;

  // Comparator
  logic [63:0]      exp_digest;
  logic             cmp_start;
  logic             cmp_done;
  mubi4_t           cmp_good;
  logic             cmp_alert;
  logic             start_alert;

  image_mem i_image_mem (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .we_i    (mem_we),
    .waddr_i (load_addr_i),
    .wdata_i (load_data_i),
    .re_i    (mem_re),
    .raddr_i (mem_raddr),
    .rdata_o (mem_rdata)
  );

  // Engine sees the memory data directly, the strobe says when it counts
  digest_engine i_digest_engine (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .clear_i      (eng_clear),
    .word_valid_i (eng_valid),
    .word_i       (mem_rdata),
    .digest_o     (digest)
  );

  rom_check_fsm i_rom_check_fsm (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .check_start_i (check_start_i),
    .load_we_i     (load_we_i),
    .mem_we_o      (mem_we),
    .mem_re_o      (mem_re),
    .mem_raddr_o   (mem_raddr),
    .mem_rdata_i   (mem_rdata),
    .eng_clear_o   (eng_clear),
    .eng_valid_o   (eng_valid),
    .exp_digest_o  (exp_digest),
    .cmp_start_o   (cmp_start),
    .cmp_done_i    (cmp_done),
    .cmp_good_i    (cmp_good),
    .bus_req_i     (bus_req_i),
    .bus_addr_i    (bus_addr_i),
    .bus_rvalid_o  (bus_rvalid_o),
    .bus_rdata_o   (bus_rdata_o),
    .start_alert_o (start_alert)
  );

  digest_compare i_digest_compare (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .start_i      (cmp_start),
    .done_o       (cmp_done),
    .good_o       (cmp_good),
    .digest_i     (digest),
    .exp_digest_i (exp_digest),
    .alert_o      (cmp_alert)
  );

  assign check_done_o = cmp_done;
  assign check_good_o = cmp_good;

  // Either misuse of start or a comparator consistency failure
  assign alert_o = start_alert | cmp_alert;

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the boot image checker testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
  -f vlog.f \
  --top-module tb_rom_check \
  -o sim_rom_check

./obj_dir/sim_rom_check | tee sim.log

if grep -q "^TEST PASSED$" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

//--- verif/tb_clock_gen.sv
// ==========================================================================
// Testbench clock at 40 ns and an active-low reset held for three rising
// edges, once at start-up and again on every rising edge of rst_req_i
// ==========================================================================

`timescale 1ns/1ps

module tb_clock_gen (
  input  logic rst_req_i,
  output logic clk_o,
  output logic rst_no
);

  // Free-running clock, 20 ns per phase
  initial begin
    clk_o = 1'b0;
    forever #20 clk_o = ~clk_o;
  end

  // Reset asserts at once and releases on a falling edge
  initial begin
    rst_no = 1'b0;
    forever begin
      repeat (3) @(posedge clk_o);
      @(negedge clk_o);
      rst_no = 1'b1;
      @(posedge rst_req_i);
      rst_no = 1'b0;
    end
  end

endmodule

//--- verif/tb_rom_check.sv
// ==========================================================================
// Directed testbench for the boot image checker. Loads random images with a
// reference digest, then checks the result, the alert and host read gating
// ==========================================================================

`timescale 1ns/1ps

module tb_rom_check
  import rom_check_pkg::*;
();

  localparam int DoneTimeout = 300;
  localparam int ReadTimeout = 8;
  localparam int RstTimeout  = 10;
  localparam int NumReads    = 8;

  logic             clk_i;
  logic             rst_ni;
  logic             rst_req;
  logic             load_we;
  logic [MemAw-1:0] load_addr;
  logic [31:0]      load_data;
  logic             check_start;
  logic             check_done;
  mubi4_t           check_good;
  logic             alert;
  logic             bus_req;
  logic [MemAw-1:0] bus_addr;
  logic             bus_rvalid;
  logic [31:0]      bus_rdata;

  // Reference copy of the loaded image for the digest and for readback
  logic [31:0]      image_q [MemWords];
  logic [MemAw-1:0] read_addrs [NumReads];

  int seed;
  int checks;
  int errors;
  int tests_run;
  int tests_failed;
  int test_errors;

  tb_clock_gen i_clock_gen (
    .rst_req_i (rst_req),
    .clk_o     (clk_i),
    .rst_no    (rst_ni)
  );

  rom_check_top i_rom_check_top (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .load_we_i     (load_we),
    .load_addr_i   (load_addr),
    .load_data_i   (load_data),
    .check_start_i (check_start),
    .check_done_o  (check_done),
    .check_good_o  (check_good),
    .alert_o       (alert),
    .bus_req_i     (bus_req),
    .bus_addr_i    (bus_addr),
    .bus_rvalid_o  (bus_rvalid),
    .bus_rdata_o   (bus_rdata)
  );

  task automatic check_value(input string what, input logic [63:0] actual,
                             input logic [63:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("ERROR @%0t: %s, got %0h, expected %0h", $time, what, actual, expected);
    end
  endtask

  // Rotate-xor-add over the data words
  // Lane A lands in the low word
  function automatic logic [63:0] ref_digest();
    logic [31:0] lane_a;
    logic [31:0] lane_b;
    lane_a = DigestIvA;
    lane_b = DigestIvB;
    for (int i = 0; i < DataWords; i++) begin
      lane_a = {lane_a[31-DigestRot:0], lane_a[31:32-DigestRot]} ^ image_q[i];
      lane_b = lane_b + lane_a;
    end
    return {lane_b, lane_a};
  endfunction

  // Random data words plus the matching digest
  // A negative bad_word keeps the digest intact
  task automatic build_image(input int bad_word);
    logic [63:0] digest;
    for (int i = 0; i < DataWords; i++) begin
      image_q[i] = $random(seed);
    end
    digest = ref_digest();
    image_q[MemWords-2] = digest[31:0];
    image_q[MemWords-1] = digest[63:32];
    // One flipped bit in the chosen expected word
    if (bad_word >= 0) begin
      image_q[MemWords-2+bad_word] = image_q[MemWords-2+bad_word] ^ 32'h0000_0100;
    end
  endtask

  // Polls on rising edges
  // Reset releases on a falling edge
  task automatic wait_reset_release();
    int cycles;
    cycles = 0;
    while (!rst_ni && cycles < RstTimeout) begin
      @(posedge clk_i);
      cycles++;
    end
    if (!rst_ni) begin
      errors++;
      $display("Timeout: reset was never released");
    end
    @(negedge clk_i);
  endtask

  task automatic reset_dut();
    @(negedge clk_i);
    rst_req = 1'b1;
    @(negedge clk_i);
    rst_req = 1'b0;
    wait_reset_release();
  endtask

  task automatic load_image();
    for (int i = 0; i < MemWords; i++) begin
      @(negedge clk_i);
      load_we   = 1'b1;
      load_addr = MemAw'(i);
      load_data = image_q[i];
    end
    @(negedge clk_i);
    load_we = 1'b0;
  endtask

  task automatic pulse_start();
    @(negedge clk_i);
    check_start = 1'b1;
    @(negedge clk_i);
    check_start = 1'b0;
  endtask

  // Ends one cycle after done so that the registered good is valid
  task automatic wait_done(input bit watch_alert);
    int cycles;
    cycles = 0;
    while (!check_done && cycles < DoneTimeout) begin
      @(negedge clk_i);
      cycles++;
      if (watch_alert) begin
        check_value("alert during check", alert, 1'b0);
      end
    end
    if (!check_done) begin
      errors++;
      $display("Timeout: check_done_o stayed low for %0d cycles", DoneTimeout);
    end
    @(negedge clk_i);
  endtask

  task automatic host_read(input logic [MemAw-1:0] addr, output logic [31:0] data);
    int cycles;
    @(negedge clk_i);
    bus_req  = 1'b1;
    bus_addr = addr;
    @(negedge clk_i);
    bus_req = 1'b0;
    cycles  = 0;
    while (!bus_rvalid && cycles < ReadTimeout) begin
      @(negedge clk_i);
      cycles++;
    end
    if (bus_rvalid) begin
      data = bus_rdata;
    end else begin
      data = '0;
      errors++;
      $display("Timeout: no read response for address %0d", addr);
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == test_errors) begin
      $display("%s: pass", name);
    end else begin
      tests_failed++;
      $display("%s: fail, %0d errors", name, errors - test_errors);
    end
  endtask

  task automatic expect_reset_values();
    logic [31:0] data;
    test_errors = errors;
    reset_dut();
    check_value("done after reset", check_done, 1'b0);
    check_value("good after reset", check_good, MuBi4False);
    check_value("alert after reset", alert, 1'b0);
    check_value("rvalid after reset", bus_rvalid, 1'b0);
    // Loaded but unchecked image stays hidden
    build_image(-1);
    load_image();
    host_read(MemAw'(3), data);
    check_value("read before check", data, 32'h0);
    host_read(MemAw'(40), data);
    check_value("read before check", data, 32'h0);
    end_test("reset_values");
  endtask

  task automatic accept_good_image();
    test_errors = errors;
    reset_dut();
    build_image(-1);
    load_image();
    pulse_start();
    wait_done(1'b1);
    check_value("done on good image", check_done, 1'b1);
    check_value("good on good image", check_good, MuBi4True);
    check_value("alert on good image", alert, 1'b0);
    end_test("good_image");
  endtask

  task automatic reject_bad_digest(input int bad_word);
    test_errors = errors;
    reset_dut();
    build_image(bad_word);
    load_image();
    pulse_start();
    wait_done(1'b1);
    check_value("done on bad digest", check_done, 1'b1);
    check_value("good on bad digest", check_good, MuBi4False);
    check_value("alert on bad digest", alert, 1'b0);
    end_test($sformatf("bad_digest_word%0d", bad_word));
  endtask

  task automatic gate_host_reads();
    logic [31:0] data;
    logic [31:0] rnd;
    test_errors = errors;
    reset_dut();
    build_image(-1);
    load_image();
    pulse_start();
    wait_done(1'b0);
    check_value("good before reads", check_good, MuBi4True);
    for (int i = 0; i < NumReads; i++) begin
      rnd           = $random(seed);
      read_addrs[i] = rnd[MemAw-1:0];
      host_read(read_addrs[i], data);
      check_value($sformatf("read after pass, addr %0d", read_addrs[i]), data,
                  image_q[read_addrs[i]]);
    end
    // Same data with a broken expected word 0
    image_q[MemWords-2] = image_q[MemWords-2] ^ 32'h0010_0000;
    reset_dut();
    load_image();
    pulse_start();
    wait_done(1'b0);
    check_value("good after corrupt image", check_good, MuBi4False);
    for (int i = 0; i < NumReads; i++) begin
      host_read(read_addrs[i], data);
      check_value($sformatf("read after fail, addr %0d", read_addrs[i]), data, 32'h0);
    end
    end_test("host_reads");
  endtask

  task automatic flag_misuse();
    logic [31:0] data;
    test_errors = errors;
    reset_dut();
    build_image(-1);
    load_image();
    pulse_start();
    // Well inside the sweep
    repeat (4) @(negedge clk_i);
    check_start = 1'b1;
    #5;
    check_value("alert on start during sweep", alert, 1'b1);
    @(negedge clk_i);
    check_start = 1'b0;
    // Write that the sequencer must block
    // Word 20 is still ahead of the sweep, so a leak would also spoil the digest
    load_we   = 1'b1;
    load_addr = MemAw'(20);
    load_data = ~image_q[20];
    @(negedge clk_i);
    load_we = 1'b0;
    wait_done(1'b1);
    check_value("good after misuse", check_good, MuBi4True);
    host_read(MemAw'(20), data);
    check_value("word 20 after blocked load", data, image_q[20]);
    end_test("misuse");
  endtask

  initial begin
    seed         = 53;
    checks       = 0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    test_errors  = 0;
    rst_req      = 1'b0;
    load_we      = 1'b0;
    load_addr    = '0;
    load_data    = '0;
    check_start  = 1'b0;
    bus_req      = 1'b0;
    bus_addr     = '0;
    // Start-up reset from the clock generator
    @(posedge clk_i);
    wait_reset_release();
    expect_reset_values();
    accept_good_image();
    reject_bad_digest(0);
    reject_bad_digest(1);
    gate_host_reads();
    flag_misuse();
    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- vlog.f
hdl/rom_check_pkg.sv
hdl/image_mem.sv
hdl/digest_engine.sv
hdl/rom_check_fsm.sv
hdl/digest_compare.sv
hdl/rom_check_top.sv
verif/tb_clock_gen.sv
verif/tb_rom_check.sv
